// ==== verilog/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and instruction word width
`define CPU_WORD_W 16

// architectural registers, r0 hardwired to zero
`define CPU_REG_CNT 16

// memory depths in words, byte address bits [8:1] select the word
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`endif

// ==== verilog/isaPkg.sv ====
package isaPkg;

	// top nibble of every instruction word
	typedef enum logic [3:0] {
		opAdd = 4'h0, // rd = rs + rt
		opSub = 4'h1, // rd = rs - rt
		opXor = 4'h2,
		opSll = 4'h4, // shift amount sits in the rt field
		opSra = 4'h5,
		opLw  = 4'h8, // rd = mem[rs + 2*off]
		opSw  = 4'h9, // mem[rs + 2*off] = rd
		opLlb = 4'hA, // low byte of rd from imm8
		opLhb = 4'hB, // high byte of rd from imm8
		opB   = 4'hC, // pc-relative, 9-bit word offset
		opBr  = 4'hD, // target from rs
		opPcs = 4'hE, // rd = pc + 2
		opHlt = 4'hF
	} opcodeT;

	// branch condition field, instr[11:9]
	typedef enum logic [2:0] {
		condNe     = 3'd0,
		condEq     = 3'd1,
		condGt     = 3'd2, // z and n both clear
		condLt     = 3'd3,
		condGe     = 3'd4,
		condLe     = 3'd5,
		condOv     = 3'd6,
		condAlways = 3'd7
	} condT;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluXor, aluSll, aluSra, aluByteLow, aluByteHigh, aluPassB
	} aluOpT;

	typedef struct packed {
		logic z; // result was zero
		logic n; // result msb
		logic v; // signed overflow on add/sub
	} flagsT;

endpackage

// ==== verilog/pipePkg.sv ====
`include "cpu_params.svh"

package pipePkg;
	import isaPkg::*;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_WORD_W-1:0] instr;
		logic [`CPU_WORD_W-1:0] pcPlus2; // needed by B and PCS
	} ifIdT;

	typedef struct packed {
		logic                   valid;
		aluOpT                  aluOp;
		logic [`CPU_WORD_W-1:0] opA;
		logic [`CPU_WORD_W-1:0] opB;
		logic [`CPU_WORD_W-1:0] storeData; // rd value for SW
		logic [3:0]             dstReg;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
		logic                   setZ; // flag update enables
		logic                   setN;
		logic                   setV;
		logic                   isHalt;
	} idExT;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_WORD_W-1:0] aluResult; // also the data address
		logic [`CPU_WORD_W-1:0] storeData;
		logic [3:0]             dstReg;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
		logic                   isHalt;
	} exMemT;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_WORD_W-1:0] wbData;
		logic [3:0]             dstReg;
		logic                   regWrite;
		logic                   isHalt;
	} memWbT;

endpackage

// ==== verilog/fetchUnit.sv ====
`include "cpu_params.svh"

module fetchUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   loadEn,
	input  logic [7:0]             loadAddr,
	input  logic [`CPU_WORD_W-1:0] loadData,
	input  logic                   redirect,
	input  logic [`CPU_WORD_W-1:0] target,
	output logic [`CPU_WORD_W-1:0] pc,
	output pipePkg::ifIdT          ifId
);
	import isaPkg::*;

	logic [`CPU_WORD_W-1:0] imem [`CPU_IMEM_DEPTH];
	logic [`CPU_WORD_W-1:0] instr;
	logic [`CPU_WORD_W-1:0] pcPlus2;
	logic                   isHlt;

	assign instr   = imem[pc[$clog2(`CPU_IMEM_DEPTH):1]]; // word addressed, async read
	assign pcPlus2 = pc + `CPU_WORD_W'(2);
	assign isHlt   = (opcodeT'(instr[15:12]) == opHlt);

	// program load only while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rstN && loadEn) begin
			imem[loadAddr] <= loadData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target; // taken branch from ID
		end else if (!isHlt) begin
			pc <= pcPlus2;
		end // on HLT pc holds and refetches it
	end

	always_ff @(posedge clk) begin
		ifId.instr   <= instr;
		ifId.pcPlus2 <= pcPlus2;
		if (!rstN || redirect) begin
			ifId.valid <= 1'b0; // squash the wrong-path fetch
		end else begin
			ifId.valid <= 1'b1;
		end
	end

endmodule

// ==== verilog/controlUnit.sv ====
`include "cpu_params.svh"

module controlUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  pipePkg::ifIdT          ifId,
	input  isaPkg::flagsT          flags,
	output logic [3:0]             srcA,
	output logic [3:0]             srcB,
	input  logic [`CPU_WORD_W-1:0] dataA,
	input  logic [`CPU_WORD_W-1:0] dataB,
	output logic                   redirect,
	output logic [`CPU_WORD_W-1:0] target,
	output pipePkg::idExT          idEx
);
	import isaPkg::*;
	import pipePkg::*;

	opcodeT                 opcode;
	condT                   cond;
	logic [3:0]             rd;
	logic [3:0]             rs;
	logic [3:0]             rt; // also shift amount and mem offset
	logic [`CPU_WORD_W-1:0] memOffset; // sign-extended, doubled
	logic [`CPU_WORD_W-1:0] brOffset; // word offset as bytes
	logic                   isBranch;
	logic                   taken;
	idExT                   idExNext;

	assign opcode    = opcodeT'(ifId.instr[15:12]);
	assign rd        = ifId.instr[11:8];
	assign rs        = ifId.instr[7:4];
	assign rt        = ifId.instr[3:0];
	assign cond      = condT'(ifId.instr[11:9]);
	assign memOffset = {{(`CPU_WORD_W-5){rt[3]}}, rt, 1'b0};
	assign brOffset  = {{(`CPU_WORD_W-10){ifId.instr[8]}}, ifId.instr[8:0], 1'b0};

	assign srcA = (opcode == opLlb || opcode == opLhb) ? rd : rs; // byte loads modify old rd
	assign srcB = (opcode == opSw) ? rd : rt; // SW stores rd

	always_comb begin
		case (cond)
			condNe:     taken = ~flags.z;
			condEq:     taken = flags.z;
			condGt:     taken = ~flags.z & ~flags.n;
			condLt:     taken = flags.n;
			condGe:     taken = flags.z | ~flags.n;
			condLe:     taken = flags.z | flags.n;
			condOv:     taken = flags.v;
			default:    taken = 1'b1; // always
		endcase
	end

	assign isBranch = (opcode == opB) || (opcode == opBr);
	assign redirect = ifId.valid & isBranch & taken; // resolved here, kills one fetch
	assign target   = (opcode == opBr) ? dataA : ifId.pcPlus2 + brOffset;

	always_comb begin
		idExNext           = '0;
		idExNext.valid     = ifId.valid & ~isBranch; // branch leaves a bubble
		idExNext.aluOp     = aluAdd;
		idExNext.opA       = dataA;
		idExNext.opB       = dataB;
		idExNext.storeData = dataB;
		idExNext.dstReg    = rd;
		case (opcode)
			opAdd, opSub: begin
				idExNext.aluOp    = (opcode == opSub) ? aluSub : aluAdd;
				idExNext.regWrite = 1'b1;
				idExNext.setZ     = 1'b1;
				idExNext.setN     = 1'b1;
				idExNext.setV     = 1'b1;
			end
			opXor, opSll, opSra: begin
				idExNext.aluOp    = (opcode == opXor) ? aluXor :
				                    (opcode == opSll) ? aluSll : aluSra;
				idExNext.regWrite = 1'b1;
				idExNext.setZ     = 1'b1; // z only for logic and shifts
				if (opcode != opXor) begin
					idExNext.opB = {{(`CPU_WORD_W-4){1'b0}}, rt}; // immediate shift amount
				end
			end
			opLw, opSw: begin
				idExNext.opB      = memOffset; // address = rs + offset
				idExNext.memRead  = (opcode == opLw);
				idExNext.memWrite = (opcode == opSw);
				idExNext.regWrite = (opcode == opLw);
			end
			opLlb, opLhb: begin
				idExNext.aluOp    = (opcode == opLlb) ? aluByteLow : aluByteHigh;
				idExNext.opB      = {{(`CPU_WORD_W-8){1'b0}}, ifId.instr[7:0]};
				idExNext.regWrite = 1'b1;
			end
			opPcs: begin
				idExNext.aluOp    = aluPassB;
				idExNext.opB      = ifId.pcPlus2;
				idExNext.regWrite = 1'b1;
			end
			opHlt:   idExNext.isHalt = 1'b1;
			default: ; // B, BR and unused codes have no effect past ID
		endcase
	end

	always_ff @(posedge clk) begin
		idEx <= idExNext;
		if (!rstN) begin
			idEx.valid <= 1'b0;
		end
	end

endmodule

// ==== verilog/regFile.sv ====
`include "cpu_params.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [3:0]             srcA,
	input  logic [3:0]             srcB,
	output logic [`CPU_WORD_W-1:0] dataA,
	output logic [`CPU_WORD_W-1:0] dataB,
	input  logic                   wrEn,
	input  logic [3:0]             wrReg,
	input  logic [`CPU_WORD_W-1:0] wrData,
	input  logic [3:0]             dbgReg,
	output logic [`CPU_WORD_W-1:0] dbgData
);

	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_CNT];

	// r0 first, then bypass of the same-cycle write
	assign dataA   = (srcA == 4'd0) ? '0 :
	                 (wrEn && wrReg == srcA) ? wrData : regs[srcA];
	assign dataB   = (srcB == 4'd0) ? '0 :
	                 (wrEn && wrReg == srcB) ? wrData : regs[srcB];
	assign dbgData = (dbgReg == 4'd0) ? '0 :
	                 (wrEn && wrReg == dbgReg) ? wrData : regs[dbgReg];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrReg != 4'd0) begin
			regs[wrReg] <= wrData; // end of WB cycle
		end
	end

endmodule

// ==== verilog/exStage.sv ====
`include "cpu_params.svh"

module exStage (
	input  logic            clk,
	input  logic            rstN,
	input  pipePkg::idExT   idEx,
	output isaPkg::flagsT   flags,
	output pipePkg::exMemT  exMem
);
	import isaPkg::*;

	localparam int Msb = `CPU_WORD_W - 1;

	logic [`CPU_WORD_W-1:0] a;
	logic [`CPU_WORD_W-1:0] b;
	logic [`CPU_WORD_W-1:0] result;
	logic [3:0]             shamt;
	logic                   ovf;

	assign a     = idEx.opA;
	assign b     = idEx.opB;
	assign shamt = b[3:0]; // only the low nibble counts

	always_comb begin
		result = b; // pass-through by default
		ovf    = 1'b0;
		case (idEx.aluOp)
			aluAdd: begin
				result = a + b; // also address generation
				ovf    = (a[Msb] == b[Msb]) && (result[Msb] != a[Msb]);
			end
			aluSub: begin
				result = a - b;
				ovf    = (a[Msb] != b[Msb]) && (result[Msb] != a[Msb]);
			end
			aluXor:      result = a ^ b;
			aluSll:      result = a << shamt;
			aluSra:      result = $signed(a) >>> shamt;
			aluByteLow:  result = {a[Msb:8], b[7:0]}; // keep old high byte
			aluByteHigh: result = {b[7:0], a[7:0]};
			default:     result = b; // PCS
		endcase
	end

	// each instruction updates only its own flags
	always_ff @(posedge clk) begin
		if (!rstN) begin
			flags <= '0;
		end else if (idEx.valid) begin
			if (idEx.setZ) begin
				flags.z <= (result == '0);
			end
			if (idEx.setN) begin
				flags.n <= result[Msb];
			end
			if (idEx.setV) begin
				flags.v <= ovf;
			end
		end
	end

	always_ff @(posedge clk) begin
		exMem.aluResult <= result;
		exMem.storeData <= idEx.storeData;
		exMem.dstReg    <= idEx.dstReg;
		exMem.regWrite  <= idEx.regWrite;
		exMem.memRead   <= idEx.memRead;
		exMem.memWrite  <= idEx.memWrite;
		exMem.isHalt    <= idEx.isHalt;
		if (!rstN) begin
			exMem.valid <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
		end
	end

endmodule

// ==== verilog/memStage.sv ====
`include "cpu_params.svh"

module memStage (
	input  logic           clk,
	input  logic           rstN,
	input  pipePkg::exMemT exMem,
	output pipePkg::memWbT memWb
);

	localparam int AddrW = $clog2(`CPU_DMEM_DEPTH);

	logic [`CPU_WORD_W-1:0] dmem [`CPU_DMEM_DEPTH];
	logic [AddrW-1:0]       addr;
	logic [`CPU_WORD_W-1:0] rdData;

	assign addr   = exMem.aluResult[AddrW:1]; // byte address to word index
	assign rdData = dmem[addr]; // async read

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.memWrite) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	always_ff @(posedge clk) begin
		memWb.wbData   <= exMem.memRead ? rdData : exMem.aluResult;
		memWb.dstReg   <= exMem.dstReg;
		memWb.regWrite <= exMem.regWrite;
		memWb.isHalt   <= exMem.isHalt; // halt travels to the end
		if (!rstN) begin
			memWb.valid <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
		end
	end

endmodule

// ==== verilog/cpuCore.sv ====
`include "cpu_params.svh"

module cpuCore (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   loadEn,
	input  logic [7:0]             loadAddr,
	input  logic [`CPU_WORD_W-1:0] loadData,
	input  logic [3:0]             dbgReg,
	output logic [`CPU_WORD_W-1:0] dbgData,
	output logic [`CPU_WORD_W-1:0] pc,
	output logic                   halted
);
	import isaPkg::*;
	import pipePkg::*;

	ifIdT                   ifId;
	idExT                   idEx;
	exMemT                  exMem;
	memWbT                  memWb;
	flagsT                  flags; // from EX back to branch logic
	logic                   redirect;
	logic [`CPU_WORD_W-1:0] target;
	logic [3:0]             srcA;
	logic [3:0]             srcB;
	logic [`CPU_WORD_W-1:0] dataA;
	logic [`CPU_WORD_W-1:0] dataB;

	// HLT refetches forever, so WB keeps seeing it once it arrives
	assign halted = memWb.valid & memWb.isHalt;

	fetchUnit fetchUnit_i (
		.clk      (clk),
		.rstN     (rstN),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.redirect (redirect),
		.target   (target),
		.pc       (pc),
		.ifId     (ifId)
	);

	controlUnit controlUnit_i (
		.clk      (clk),
		.rstN     (rstN),
		.ifId     (ifId),
		.flags    (flags),
		.srcA     (srcA),
		.srcB     (srcB),
		.dataA    (dataA),
		.dataB    (dataB),
		.redirect (redirect),
		.target   (target),
		.idEx     (idEx)
	);

	regFile regFile_i (
		.clk     (clk),
		.rstN    (rstN),
		.srcA    (srcA),
		.srcB    (srcB),
		.dataA   (dataA),
		.dataB   (dataB),
		.wrEn    (memWb.valid & memWb.regWrite), // bubbles never write
		.wrReg   (memWb.dstReg),
		.wrData  (memWb.wbData),
		.dbgReg  (dbgReg),
		.dbgData (dbgData)
	);

	exStage exStage_i (
		.clk   (clk),
		.rstN  (rstN),
		.idEx  (idEx),
		.flags (flags),
		.exMem (exMem)
	);

	memStage memStage_i (
		.clk   (clk),
		.rstN  (rstN),
		.exMem (exMem),
		.memWb (memWb)
	);

endmodule

// ==== testbench/cpuCoreTb.sv ====
`include "cpu_params.svh"

module cpuCoreTb;

	localparam int ClkPeriod = 100;
	localparam int NumTests  = 6; // watchdog budget is 200 cycles per test
	localparam int OpAdd     = 0;
	localparam int OpSub     = 1;
	localparam int OpXor     = 2;
	localparam int OpSll     = 4;
	localparam int OpSra     = 5;
	localparam int OpLw      = 8;
	localparam int OpSw      = 9;
	localparam int OpLlb     = 10;
	localparam int OpLhb     = 11;
	localparam int OpPcs     = 14;

	logic                   clk = 1'b0;
	logic                   rstN;
	logic                   loadEn;
	logic [7:0]             loadAddr;
	logic [`CPU_WORD_W-1:0] loadData;
	logic [3:0]             dbgReg;
	logic [`CPU_WORD_W-1:0] dbgData;
	logic [`CPU_WORD_W-1:0] pc;
	logic                   halted;

	logic [15:0] prog [$]; // program image with one word per entry
	logic [15:0] expReg [16]; // register file as the ISA says it should end
	logic [31:0] lfsr = 32'h29d9_12f2;

	always #(ClkPeriod / 2) clk = ~clk;

	cpuCore cpuCore_i (
		.clk      (clk),
		.rstN     (rstN),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.dbgReg   (dbgReg),
		.dbgData  (dbgData),
		.pc       (pc),
		.halted   (halted)
	);

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois form shifting right
	endfunction

	task automatic randomBits(input int n, output logic [15:0] w);
		int i;
		w = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr); // one step per bit taken
			w    = {w[14:0], lfsr[0]};
		end
	endtask

	// instruction encoders
	function automatic logic [15:0] encR(input int op, input int rd, input int rs, input int rt);
		return {4'(op), 4'(rd), 4'(rs), 4'(rt)}; // rt doubles as shamt or mem offset
	endfunction

	function automatic logic [15:0] encImm(input int op, input int rd, input logic [7:0] imm);
		return {4'(op), 4'(rd), imm};
	endfunction

	function automatic logic [15:0] encB(input int cond, input int off);
		return {4'hC, 3'(cond), 9'(off)}; // word offset from pc+2
	endfunction

	function automatic logic [15:0] encBr(input int cond, input int rs);
		return {4'hD, 3'(cond), 1'b0, 4'(rs), 4'h0};
	endfunction

	// flags a SUB leaves behind packed as {z, n, v}
	function automatic logic [2:0] subFlags(input logic [15:0] a, input logic [15:0] b);
		int d;
		d = int'($signed(a)) - int'($signed(b)); // exact signed difference
		return {a == b, d[15], (d > 32767) || (d < -32768)};
	endfunction

	function automatic logic condTaken(input int cond, input logic [2:0] f);
		logic z;
		logic n;
		logic v;
		{z, n, v} = f;
		case (cond)
			0:       return !z; // ne
			1:       return z;
			2:       return !z && !n; // gt
			3:       return n;
			4:       return z || !n; // ge
			5:       return z || n;
			6:       return v; // ov
			default: return 1'b1;
		endcase
	endfunction

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	task automatic emitNop(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			emit(encR(OpAdd, 0, 0, 0));
		end
	endtask

	task automatic setExpected(input int rd, input logic [15:0] v);
		if (rd != 0) begin
			expReg[rd] = v; // r0 stays zero
		end
	endtask

	task automatic newProgram();
		int i;
		prog.delete();
		for (i = 0; i < 16; i++) begin
			expReg[i] = 16'h0;
		end
	endtask

	// three registers built with LLB then LHB spaced so every LHB sees its LLB
	task automatic loadRegs(input int ra, input int rb, input int rc,
			input logic [15:0] va, input logic [15:0] vb, input logic [15:0] vc);
		emit(encImm(OpLlb, ra, va[7:0]));
		emit(encImm(OpLlb, rb, vb[7:0]));
		emit(encImm(OpLlb, rc, vc[7:0]));
		emit(encImm(OpLhb, ra, va[15:8]));
		emit(encImm(OpLhb, rb, vb[15:8]));
		emit(encImm(OpLhb, rc, vc[15:8]));
		emitNop(2); // results usable right after this
		setExpected(ra, va);
		setExpected(rb, vb);
		setExpected(rc, vc);
	endtask

	// hold reset, load the image, release and wait for halted
	task automatic runProgram();
		int n;
		int i;
		n = (prog.size() > 16) ? prog.size() : 16; // at least 16 reset cycles
		@(negedge clk);
		rstN = 1'b0;
		for (i = 0; i < n; i++) begin
			loadEn   = (i < prog.size());
			loadAddr = 8'(i);
			loadData = (i < prog.size()) ? prog[i] : 16'h0;
			@(negedge clk);
		end
		loadEn = 1'b0;
		assert (pc === 16'h0000) else begin
			$display("Mismatch pc during reset: expected %h, actual %h", 16'h0000, pc);
			abortRun();
		end
		assert (halted === 1'b0) else begin
			$display("halted is high while the core is held in reset");
			abortRun();
		end
		rstN = 1'b1;
		while (halted !== 1'b1) begin
			@(negedge clk); // watchdog catches a hang
		end
	endtask

	task automatic checkAllRegs();
		int r;
		for (r = 0; r < 16; r++) begin
			@(negedge clk);
			dbgReg = 4'(r);
			@(negedge clk); // a full cycle for the debug read to settle
			assert (dbgData === expReg[r]) else begin
				$display("Mismatch r%0d: expected %h, actual %h", r, expReg[r], dbgData);
				abortRun();
			end
		end
	endtask

	task automatic arithmeticTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] sh1;
		logic [15:0] sh2;
		logic [15:0] sh3;
		newProgram();
		randomBits(16, a);
		randomBits(16, b);
		randomBits(16, c);
		c[15] = 1'b1; // negative operand for SRA
		randomBits(4, sh1);
		randomBits(4, sh2);
		randomBits(4, sh3);
		loadRegs(1, 2, 3, a, b, c);
		emit(encR(OpAdd, 4, 1, 2));
		emit(encR(OpSub, 5, 1, 3));
		emit(encR(OpXor, 6, 2, 3));
		emit(encR(OpSll, 7, 1, int'(sh1)));
		emit(encR(OpSra, 8, 3, int'(sh2)));
		emit(encR(OpSra, 9, 2, int'(sh3)));
		emit(encR(OpSub, 10, 2, 2)); // self subtract gives zero
		emit(16'hF000);
		setExpected(4, a + b);
		setExpected(5, a - c);
		setExpected(6, b ^ c);
		setExpected(7, a << sh1[3:0]);
		setExpected(8, 16'({{16{c[15]}}, c} >> sh2[3:0])); // sign copies shifted in
		setExpected(9, 16'({{16{b[15]}}, b} >> sh3[3:0]));
		setExpected(10, 16'h0000);
		runProgram();
		checkAllRegs();
	endtask

	task automatic memoryTest();
		logic [15:0] w2;
		logic [15:0] w3;
		logic [15:0] w4;
		logic [15:0] w5;
		newProgram();
		randomBits(16, w2);
		randomBits(16, w3);
		randomBits(16, w4);
		randomBits(16, w5);
		loadRegs(1, 2, 3, 16'h0040, w2, w3); // r1 is the base address
		loadRegs(4, 5, 0, w4, w5, 16'h0000);
		emit(encR(OpSw, 2, 1, 0));
		emit(encR(OpSw, 3, 1, 3)); // byte offset 6
		emit(encR(OpSw, 4, 1, -2)); // below the base
		emit(encR(OpSw, 5, 1, 7));
		emit(encR(OpLw, 6, 1, 0));
		emit(encR(OpLw, 7, 1, 7));
		emit(encR(OpLw, 8, 1, -2));
		emit(encR(OpLw, 9, 1, 3));
		emit(16'hF000);
		setExpected(6, w2);
		setExpected(7, w5);
		setExpected(8, w4);
		setExpected(9, w3);
		runProgram();
		checkAllRegs();
	endtask

	// SUB into r0 sets flags only and the marker is written on fall-through
	task automatic branchCase(input int cond, input int rx, input int ry,
			input logic [15:0] vx, input logic [15:0] vy, input int marker);
		emit(encR(OpSub, 0, rx, ry));
		emitNop(1); // exactly one since the NOP sets flags too
		emit(encB(cond, 1)); // skips the marker when taken
		emit(encImm(OpLlb, marker, 8'h01));
		setExpected(marker, condTaken(cond, subFlags(vx, vy)) ? 16'h0000 : 16'h0001);
	endtask

	task automatic branchTest();
		newProgram();
		loadRegs(1, 2, 3, 16'h0005, 16'h0003, 16'h7FFF);
		loadRegs(4, 0, 0, 16'hFFFF, 16'h0000, 16'h0000);
		branchCase(0, 1, 1, 16'h0005, 16'h0005, 5); // ne on equal values
		branchCase(1, 1, 1, 16'h0005, 16'h0005, 6);
		branchCase(2, 1, 2, 16'h0005, 16'h0003, 7);
		branchCase(3, 2, 1, 16'h0003, 16'h0005, 8);
		branchCase(4, 2, 1, 16'h0003, 16'h0005, 9);
		branchCase(5, 1, 2, 16'h0005, 16'h0003, 10);
		branchCase(6, 3, 4, 16'h7FFF, 16'hFFFF, 11); // max positive minus -1
		branchCase(7, 2, 2, 16'h0003, 16'h0003, 12);
		emit(16'hF000);
		runProgram();
		checkAllRegs();
	endtask

	task automatic brPcsTest();
		int tgt;
		tgt = 10; // word index of the BR target
		newProgram();
		emit(encR(OpPcs, 1, 0, 0)); // r1 = 2
		emit(encImm(OpLlb, 7, 8'(2 * tgt - 2)));
		emitNop(2);
		emit(encR(OpAdd, 2, 1, 7)); // r2 = byte address of target
		emitNop(2);
		emit(encBr(7, 2));
		emit(encImm(OpLlb, 3, 8'h77)); // killed behind the taken BR
		emit(encImm(OpLlb, 4, 8'h66)); // jumped over
		setExpected(1, 16'h0002);
		setExpected(7, 16'(2 * tgt - 2));
		setExpected(2, 16'(2 * tgt));
		setExpected(6, 16'(2 * prog.size() + 2));
		emit(encR(OpPcs, 6, 0, 0));
		emit(16'hF000);
		runProgram();
		checkAllRegs();
	endtask

	task automatic haltTest();
		logic [15:0] hltAddr;
		int i;
		newProgram();
		emit(encImm(OpLlb, 1, 8'h11));
		emitNop(1);
		hltAddr = 16'(2 * prog.size());
		emit(16'hF000);
		emit(encImm(OpLlb, 2, 8'h22)); // never fetched
		emit(encImm(OpLlb, 3, 8'h33));
		emit(encR(OpAdd, 4, 1, 1));
		setExpected(1, 16'h0011);
		runProgram();
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			assert (halted === 1'b1) else begin
				$display("halted dropped after the HLT reached writeback");
				abortRun();
			end
			assert (pc === hltAddr) else begin
				$display("Mismatch pc: expected %h, actual %h", hltAddr, pc);
				abortRun();
			end
		end
		checkAllRegs();
	endtask

	task automatic resetTest();
		logic [15:0] x;
		logic [15:0] y;
		newProgram();
		randomBits(16, x);
		randomBits(16, y);
		loadRegs(11, 12, 13, x, y, 16'h00FF);
		emit(encR(OpAdd, 14, 11, 12));
		emit(16'hF000);
		setExpected(14, x + y);
		runProgram(); // r1 from the halt test must be cleared
		checkAllRegs();
		runProgram();
		checkAllRegs();
	endtask

	initial begin
		rstN     = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		dbgReg   = '0;
		arithmeticTest();
		memoryTest();
		branchTest();
		brPcsTest();
		haltTest();
		resetTest();
		$display("Finished with no errors");
		$finish;
	end

	initial begin
		#(NumTests * 200 * ClkPeriod);
		$display("Timeout, the core never reached halt within %0d cycles", NumTests * 200);
		abortRun();
	end

endmodule

// ==== cpuPipe.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchUnit.sv
verilog/controlUnit.sv
verilog/regFile.sv
verilog/exStage.sv
verilog/memStage.sv
verilog/cpuCore.sv
testbench/cpuCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := cpuCoreTb
FILELIST  := cpuPipe.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
